// ==== Bender.yml ====
package:
  name: fpgarr_axil

sources:
  - files:
      - fpgarr_pkg.sv
      - channel_siderec.sv
      - axil_mstr_recorder.sv
      - rec_packet_packer.sv
      - rec_log_buffer.sv
      - axil_reg_target.sv
      - fpgarr_axil_top.sv
  - target: test
    files:
      - fpgarr_properties.sv
      - tb_fpgarr.sv

// ==== axil_mstr_recorder.sv ====
`timescale 1ns/1ns

module axil_mstr_recorder (
   input  logic                    clk,
   input  logic                    arst_n,
   input  fpgarr_pkg::axil_req_t   host_req,
   output fpgarr_pkg::axil_rsp_t   host_rsp,
   output fpgarr_pkg::axil_req_t   tgt_req,
   input  fpgarr_pkg::axil_rsp_t   tgt_rsp,
   output fpgarr_pkg::rec_bundle_t rec_out,
   output logic                    rec_valid,
   input  logic                    rec_ready
);

   // Index 0 is AW, 1 is W, 2 is AR
   logic [2:0]           chan_valid;
   logic [2:0]           new_packet;
   logic [2:0]           fwd_valid;
   logic [2:0]           host_ready;
   fpgarr_pkg::rec_hdr_t hdr [3];
   logic                 bubble_en;
   logic                 rec_pop;

   logic [fpgarr_pkg::AXIL_RR_AW_WIDTH-1:0] aw_rec;
   logic [fpgarr_pkg::AXIL_RR_W_WIDTH-1:0]  w_rec;
   logic [fpgarr_pkg::AXIL_RR_AR_WIDTH-1:0] ar_rec;

   assign bubble_en = |new_packet;
   assign rec_valid = &chan_valid;
   assign rec_pop   = rec_valid & rec_ready;

   channel_siderec #(.WIDTH(fpgarr_pkg::AXIL_RR_AW_WIDTH)) chan_aw (
      .clk        (clk),
      .arst_n     (arst_n),
      .din        (host_req.awaddr),
      .sh_valid   (host_req.awvalid),
      .cl_ready   (tgt_rsp.awready),
      .bubble_en  (bubble_en),
      .rec_ready  (rec_pop),
      .sh_ready   (host_ready[0]),
      .cl_valid   (fwd_valid[0]),
      .new_packet (new_packet[0]),
      .rec_valid  (chan_valid[0]),
      .hdr_out    (hdr[0]),
      .dout       (aw_rec)
   );

   channel_siderec #(.WIDTH(fpgarr_pkg::AXIL_RR_W_WIDTH)) chan_w (
      .clk        (clk),
      .arst_n     (arst_n),
      .din        ({host_req.wdata, host_req.wstrb}),
      .sh_valid   (host_req.wvalid),
      .cl_ready   (tgt_rsp.wready),
      .bubble_en  (bubble_en),
      .rec_ready  (rec_pop),
      .sh_ready   (host_ready[1]),
      .cl_valid   (fwd_valid[1]),
      .new_packet (new_packet[1]),
      .rec_valid  (chan_valid[1]),
      .hdr_out    (hdr[1]),
      .dout       (w_rec)
   );

   // AR pops with the others so the three queues never drift apart
   channel_siderec #(.WIDTH(fpgarr_pkg::AXIL_RR_AR_WIDTH)) chan_ar (
      .clk        (clk),
      .arst_n     (arst_n),
      .din        (host_req.araddr),
      .sh_valid   (host_req.arvalid),
      .cl_ready   (tgt_rsp.arready),
      .bubble_en  (bubble_en),
      .rec_ready  (rec_pop),
      .sh_ready   (host_ready[2]),
      .cl_valid   (fwd_valid[2]),
      .new_packet (new_packet[2]),
      .rec_valid  (chan_valid[2]),
      .hdr_out    (hdr[2]),
      .dout       (ar_rec)
   );

   // Requests go out with gated valids, responses come back untouched
   always_comb begin
      tgt_req         = host_req;
      tgt_req.awvalid = fwd_valid[0];
      tgt_req.wvalid  = fwd_valid[1];
      tgt_req.arvalid = fwd_valid[2];

      host_rsp         = tgt_rsp;
      host_rsp.awready = host_ready[0];
      host_rsp.wready  = host_ready[1];
      host_rsp.arready = host_ready[2];
   end

   always_comb begin
      rec_out.aw_hdr = hdr[0];
      rec_out.w_hdr  = hdr[1];
      rec_out.ar_hdr = hdr[2];
      rec_out.aw     = aw_rec;
      rec_out.w      = w_rec;
      rec_out.ar     = ar_rec;
   end

endmodule

// ==== axil_reg_target.sv ====
`timescale 1ns/1ns

module axil_reg_target (
   input  logic                  clk,
   input  logic                  arst_n,
   input  fpgarr_pkg::axil_req_t req,
   output fpgarr_pkg::axil_rsp_t rsp
);

   logic [fpgarr_pkg::AXIL_DATA_W-1:0] regs [fpgarr_pkg::REG_COUNT];
   fpgarr_pkg::tgt_state_e             state;
   logic                               wr_go;
   logic                               ar_go;
   logic                               rd_pend;
   logic [1:0]                         ar_idx_q;
   logic [1:0]                         wr_idx;
   logic [fpgarr_pkg::AXIL_DATA_W-1:0] rdata_q;

   // AW and W are taken together, AR may ride along in the same cycle
   assign wr_go  = (state == fpgarr_pkg::TGT_IDLE) & req.awvalid & req.wvalid;
   assign ar_go  = (state == fpgarr_pkg::TGT_IDLE) & req.arvalid;
   assign wr_idx = req.awaddr[3:2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= fpgarr_pkg::TGT_IDLE;
         rd_pend <= 1'b0;
         for (int i = 0; i < fpgarr_pkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else begin
         case (state)
            fpgarr_pkg::TGT_IDLE: begin
               if (wr_go) begin
                  for (int b = 0; b < fpgarr_pkg::AXIL_STRB_W; b++) begin
                     if (req.wstrb[b]) begin
                        regs[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                     end
                  end
                  state   <= fpgarr_pkg::TGT_BRESP;
                  rd_pend <= ar_go;
               end else if (ar_go) begin
                  state <= fpgarr_pkg::TGT_RRESP;
               end
            end
            fpgarr_pkg::TGT_BRESP: begin
               // Write answers first, then a read taken alongside it
               if (req.bready) begin
                  state   <= rd_pend ? fpgarr_pkg::TGT_RRESP : fpgarr_pkg::TGT_IDLE;
                  rd_pend <= 1'b0;
               end
            end
            fpgarr_pkg::TGT_RRESP: begin
               if (req.rready) begin
                  state <= fpgarr_pkg::TGT_IDLE;
               end
            end
            default: state <= fpgarr_pkg::TGT_IDLE;
         endcase
      end
   end

   // Read data is sampled when the R phase starts, so it sees any write before it
   always_ff @(posedge clk) begin
      if (ar_go) begin
         ar_idx_q <= req.araddr[3:2];
      end
      if (ar_go && !wr_go) begin
         rdata_q <= regs[req.araddr[3:2]];
      end else if (state == fpgarr_pkg::TGT_BRESP && req.bready && rd_pend) begin
         rdata_q <= regs[ar_idx_q];
      end
   end

   always_comb begin
      rsp.awready = wr_go;
      rsp.wready  = wr_go;
      rsp.bresp   = fpgarr_pkg::AXI_RESP_OKAY;
      rsp.bvalid  = (state == fpgarr_pkg::TGT_BRESP);
      rsp.arready = ar_go;
      rsp.rdata   = rdata_q;
      rsp.rresp   = fpgarr_pkg::AXI_RESP_OKAY;
      rsp.rvalid  = (state == fpgarr_pkg::TGT_RRESP);
   end

endmodule

// ==== channel_siderec.sv ====
`timescale 1ns/1ns

module channel_siderec #(
   parameter int WIDTH = 32
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic [WIDTH-1:0]     din,
   input  logic                 sh_valid,
   input  logic                 cl_ready,
   input  logic                 bubble_en,
   input  logic                 rec_ready,
   output logic                 sh_ready,
   output logic                 cl_valid,
   output logic                 new_packet,
   output logic                 rec_valid,
   output fpgarr_pkg::rec_hdr_t hdr_out,
   output logic [WIDTH-1:0]     dout
);

   logic [WIDTH-1:0]     data_mem [fpgarr_pkg::FIFO_DEPTH];
   fpgarr_pkg::rec_hdr_t hdr_mem [fpgarr_pkg::FIFO_DEPTH];

   logic [fpgarr_pkg::FIFO_PTR_W-1:0] wr_ptr;
   logic [fpgarr_pkg::FIFO_PTR_W-1:0] rd_ptr;
   logic [fpgarr_pkg::FIFO_PTR_W:0]   count;
   logic                              has_room;
   logic                              push;
   logic                              pop;
   fpgarr_pkg::rec_hdr_t              hdr_in;

   // Forwarding is only allowed while the record can be stored
   assign has_room   = (count < fpgarr_pkg::FIFO_DEPTH);
   assign cl_valid   = sh_valid & has_room;
   assign sh_ready   = cl_ready & has_room;
   assign new_packet = cl_valid & cl_ready;

   // All queues push together, so a bubble lands here when another channel moves
   assign push      = bubble_en & has_room;
   assign rec_valid = (count != '0);
   assign pop       = rec_ready & rec_valid;

   always_comb begin
      hdr_in.ispkt = new_packet;
      // Host was waiting on this channel but nothing went through
      hdr_in.busy  = sh_valid & ~new_packet;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr] <= din;
         hdr_mem[wr_ptr]  <= hdr_in;
      end
   end

   assign dout    = data_mem[rd_ptr];
   assign hdr_out = hdr_mem[rd_ptr];

endmodule

// ==== fpgarr_axil_top.sv ====
`timescale 1ns/1ns

module fpgarr_axil_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  fpgarr_pkg::axil_req_t  host_req,
   output fpgarr_pkg::axil_rsp_t  host_rsp,
   output fpgarr_pkg::log_entry_t log_entry,
   output logic                   log_valid,
   input  logic                   log_ready
);

   fpgarr_pkg::axil_req_t   tgt_req;
   fpgarr_pkg::axil_rsp_t   tgt_rsp;
   fpgarr_pkg::rec_bundle_t rec_bundle;
   logic                    rec_valid;
   logic                    rec_ready;
   fpgarr_pkg::log_entry_t  pk_entry;
   logic                    pk_valid;
   logic                    pk_ready;

   axil_mstr_recorder u_recorder (
      .clk       (clk),
      .arst_n    (arst_n),
      .host_req  (host_req),
      .host_rsp  (host_rsp),
      .tgt_req   (tgt_req),
      .tgt_rsp   (tgt_rsp),
      .rec_out   (rec_bundle),
      .rec_valid (rec_valid),
      .rec_ready (rec_ready)
   );

   axil_reg_target u_target (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (tgt_req),
      .rsp    (tgt_rsp)
   );

   rec_packet_packer u_packer (
      .clk         (clk),
      .arst_n      (arst_n),
      .rec_in      (rec_bundle),
      .rec_valid   (rec_valid),
      .rec_ready   (rec_ready),
      .entry_out   (pk_entry),
      .entry_valid (pk_valid),
      .entry_ready (pk_ready)
   );

   rec_log_buffer u_log_buf (
      .clk         (clk),
      .arst_n      (arst_n),
      .entry_in    (pk_entry),
      .entry_valid (pk_valid),
      .entry_ready (pk_ready),
      .log_entry   (log_entry),
      .log_valid   (log_valid),
      .log_ready   (log_ready)
   );

endmodule

// ==== fpgarr_pkg.sv ====
package fpgarr_pkg;

   // AXI-Lite bus widths
   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // Recorded payload widths per request channel
   localparam int AXIL_RR_AW_WIDTH = AXIL_ADDR_W;
   localparam int AXIL_RR_W_WIDTH = AXIL_DATA_W + AXIL_STRB_W;
   localparam int AXIL_RR_AR_WIDTH = AXIL_ADDR_W;

   // Side-record queues and log buffer
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int LOG_DEPTH = 4;
   localparam int LOG_PTR_W = $clog2(LOG_DEPTH);
   localparam int SEQ_W = 8;

   // Register target
   localparam int REG_COUNT = 4;
   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] awaddr;
      logic                   awvalid;
      logic [AXIL_DATA_W-1:0] wdata;
      logic [AXIL_STRB_W-1:0] wstrb;
      logic                   wvalid;
      logic [AXIL_ADDR_W-1:0] araddr;
      logic                   arvalid;
      logic                   bready;
      logic                   rready;
   } axil_req_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic [1:0]             bresp;
      logic                   bvalid;
      logic                   arready;
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
      logic                   rvalid;
   } axil_rsp_t;

   // ispkt clear means a bubble entry
   typedef struct packed {
      logic ispkt;
      logic busy;
   } rec_hdr_t;

   typedef struct packed {
      rec_hdr_t                    aw_hdr;
      rec_hdr_t                    w_hdr;
      rec_hdr_t                    ar_hdr;
      logic [AXIL_RR_AW_WIDTH-1:0] aw;
      logic [AXIL_RR_W_WIDTH-1:0]  w;
      logic [AXIL_RR_AR_WIDTH-1:0] ar;
   } rec_bundle_t;

   typedef struct packed {
      logic [SEQ_W-1:0] seq;
      rec_bundle_t      bundle;
   } log_entry_t;

   typedef enum logic [1:0] {
      TGT_IDLE,
      TGT_BRESP,
      TGT_RRESP
   } tgt_state_e;

endpackage

// ==== fpgarr_properties.sv ====
`timescale 1ns/1ns

module fpgarr_properties (
   input logic                   clk,
   input logic                   arst_n,
   input fpgarr_pkg::axil_req_t  host_req,
   input fpgarr_pkg::axil_rsp_t  host_rsp,
   input fpgarr_pkg::log_entry_t log_entry,
   input logic                   log_valid,
   input logic                   log_ready
);

   int                           fail_count = 0;
   logic [fpgarr_pkg::SEQ_W-1:0] last_seq;
   logic [fpgarr_pkg::SEQ_W-1:0] next_seq;
   logic                         seq_known;

   // Wraps at the sequence width
   assign next_seq = last_seq + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last_seq  <= '0;
         seq_known <= 1'b0;
      end else if (log_valid && log_ready) begin
         last_seq  <= log_entry.seq;
         seq_known <= 1'b1;
      end
   end

   log_hold: assert property (@(posedge clk) disable iff (!arst_n)
      log_valid && !log_ready |=> log_valid && $stable(log_entry))
      else begin
         $error("log entry changed before it was taken");
         fail_count++;
      end

   b_hold: assert property (@(posedge clk) disable iff (!arst_n)
      host_rsp.bvalid && !host_req.bready |=> host_rsp.bvalid)
      else begin
         $error("bvalid dropped before bready");
         fail_count++;
      end

   r_hold: assert property (@(posedge clk) disable iff (!arst_n)
      host_rsp.rvalid && !host_req.rready |=> host_rsp.rvalid)
      else begin
         $error("rvalid dropped before rready");
         fail_count++;
      end

   reset_quiet: assert property (@(posedge clk)
      !arst_n |-> !log_valid && !host_rsp.bvalid && !host_rsp.rvalid)
      else begin
         $error("valid output high during reset");
         fail_count++;
      end

   seq_step: assert property (@(posedge clk) disable iff (!arst_n)
      log_valid && log_ready && seq_known |-> log_entry.seq == next_seq)
      else begin
         $error("log sequence number skipped");
         fail_count++;
      end

endmodule

bind fpgarr_axil_top fpgarr_properties props (.*);

// ==== project.f ====
fpgarr_pkg.sv
channel_siderec.sv
axil_mstr_recorder.sv
rec_packet_packer.sv
rec_log_buffer.sv
axil_reg_target.sv
fpgarr_axil_top.sv
fpgarr_properties.sv
tb_fpgarr.sv

// ==== rec_log_buffer.sv ====
`timescale 1ns/1ns

module rec_log_buffer (
   input  logic                   clk,
   input  logic                   arst_n,
   input  fpgarr_pkg::log_entry_t entry_in,
   input  logic                   entry_valid,
   output logic                   entry_ready,
   output fpgarr_pkg::log_entry_t log_entry,
   output logic                   log_valid,
   input  logic                   log_ready
);

   fpgarr_pkg::log_entry_t mem [fpgarr_pkg::LOG_DEPTH];

   logic [fpgarr_pkg::LOG_PTR_W-1:0] wr_ptr;
   logic [fpgarr_pkg::LOG_PTR_W-1:0] rd_ptr;
   logic [fpgarr_pkg::LOG_PTR_W:0]   count;
   logic                             push;
   logic                             pop;

   assign entry_ready = (count < fpgarr_pkg::LOG_DEPTH);
   assign log_valid   = (count != '0);
   assign push        = entry_valid & entry_ready;
   assign pop         = log_valid & log_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= entry_in;
      end
   end

   // Head stays put until the outside takes it
   assign log_entry = mem[rd_ptr];

endmodule

// ==== rec_packet_packer.sv ====
`timescale 1ns/1ns

module rec_packet_packer (
   input  logic                    clk,
   input  logic                    arst_n,
   input  fpgarr_pkg::rec_bundle_t rec_in,
   input  logic                    rec_valid,
   output logic                    rec_ready,
   output fpgarr_pkg::log_entry_t  entry_out,
   output logic                    entry_valid,
   input  logic                    entry_ready
);

   logic [fpgarr_pkg::SEQ_W-1:0] seq_cnt;
   logic                         valid_q;
   logic                         accept;
   fpgarr_pkg::log_entry_t       entry_q;

   // Stage frees up in the same cycle its entry leaves
   assign rec_ready = ~valid_q | entry_ready;
   assign accept    = rec_valid & rec_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
         seq_cnt <= '0;
      end else begin
         if (accept) begin
            valid_q <= 1'b1;
            // Wraps at 2**SEQ_W
            seq_cnt <= seq_cnt + 1'b1;
         end else if (entry_ready) begin
            valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         entry_q.seq    <= seq_cnt;
         entry_q.bundle <= rec_in;
      end
   end

   assign entry_out   = entry_q;
   assign entry_valid = valid_q;

endmodule

// ==== tb_fpgarr.sv ====
`timescale 1ns/1ns

module tb_fpgarr;

   localparam int TIMEOUT_CYCLES = 5000;
   localparam int RANDOM_OPS = 20;
   localparam int STALL_WRITES = 16;

   logic                   clk;
   logic                   arst_n;
   fpgarr_pkg::axil_req_t  host_req;
   fpgarr_pkg::axil_rsp_t  host_rsp;
   fpgarr_pkg::log_entry_t log_entry;
   logic                   log_valid;
   logic                   log_ready;

   integer                             seed;
   int                                 cycle_count = 0;
   int                                 triple_seen = 0;
   logic [fpgarr_pkg::SEQ_W-1:0]       exp_seq = '0;
   logic                               stall_seen;
   logic                               writes_done;
   string                              test_name = "none";
   logic [fpgarr_pkg::AXIL_DATA_W-1:0] ref_regs [fpgarr_pkg::REG_COUNT];
   fpgarr_pkg::rec_bundle_t            exp_q [$];

   fpgarr_axil_top dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .host_req  (host_req),
      .host_rsp  (host_rsp),
      .log_entry (log_entry),
      .log_valid (log_valid),
      .log_ready (log_ready)
   );

   always #10 clk = ~clk;

   task automatic fail_run(input string reason);
      $display("Simulation failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_value(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
      assert (actual === expected) else begin
         $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
         fail_run("value mismatch");
      end
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      host_req.awaddr  <= addr;
      host_req.awvalid <= 1'b1;
      host_req.wdata   <= data;
      host_req.wstrb   <= strb;
      host_req.wvalid  <= 1'b1;
      do @(posedge clk); while (!host_rsp.awready);
      check_value("wready with awready", 1, host_rsp.wready);
      for (int b = 0; b < fpgarr_pkg::AXIL_STRB_W; b++) begin
         if (strb[b]) begin
            ref_regs[addr[3:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
      host_req.awvalid <= 1'b0;
      host_req.wvalid  <= 1'b0;
      do @(posedge clk); while (!host_rsp.bvalid);
      check_value("bresp", 2'b00, host_rsp.bresp);
      host_req.bready <= 1'b1;
      @(posedge clk);
      host_req.bready <= 1'b0;
   endtask

   task automatic read_reg(input logic [31:0] addr);
      host_req.araddr  <= addr;
      host_req.arvalid <= 1'b1;
      do @(posedge clk); while (!host_rsp.arready);
      host_req.arvalid <= 1'b0;
      do @(posedge clk); while (!host_rsp.rvalid);
      // Model already holds any write accepted with this read
      check_value("rdata", ref_regs[addr[3:2]], host_rsp.rdata);
      check_value("rresp", 2'b00, host_rsp.rresp);
      host_req.rready <= 1'b1;
      @(posedge clk);
      host_req.rready <= 1'b0;
   endtask

   // One expected bundle per cycle with any request handshake
   always @(posedge clk) begin : record_monitor
      logic [2:0]              hs;
      fpgarr_pkg::rec_bundle_t exp;
      hs[0] = host_req.awvalid & host_rsp.awready;
      hs[1] = host_req.wvalid & host_rsp.wready;
      hs[2] = host_req.arvalid & host_rsp.arready;
      if (arst_n && hs != 3'b000) begin
         exp.aw_hdr.ispkt = hs[0];
         exp.aw_hdr.busy  = host_req.awvalid & ~hs[0];
         exp.w_hdr.ispkt  = hs[1];
         exp.w_hdr.busy   = host_req.wvalid & ~hs[1];
         exp.ar_hdr.ispkt = hs[2];
         exp.ar_hdr.busy  = host_req.arvalid & ~hs[2];
         exp.aw           = host_req.awaddr;
         exp.w            = {host_req.wdata, host_req.wstrb};
         exp.ar           = host_req.araddr;
         exp_q.push_back(exp);
      end
   end

   always @(posedge clk) begin : log_checker
      fpgarr_pkg::rec_bundle_t exp;
      fpgarr_pkg::rec_bundle_t act;
      if (arst_n && log_valid && log_ready) begin
         assert (exp_q.size() != 0) else begin
            $display("A log entry appeared without a matching request handshake");
            fail_run("unexpected log entry");
         end
         exp = exp_q.pop_front();
         act = log_entry.bundle;
         // Bubble payloads carry no meaning
         if (!exp.aw_hdr.ispkt) begin
            exp.aw = '0;
            act.aw = '0;
         end
         if (!exp.w_hdr.ispkt) begin
            exp.w = '0;
            act.w = '0;
         end
         if (!exp.ar_hdr.ispkt) begin
            exp.ar = '0;
            act.ar = '0;
         end
         check_value("log seq", exp_seq, log_entry.seq);
         check_value("log bundle", exp, act);
         if (act.aw_hdr.ispkt && act.w_hdr.ispkt && act.ar_hdr.ispkt) begin
            triple_seen++;
         end
         exp_seq = exp_seq + 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         fail_run("timeout");
      end else if (dut.props.fail_count != 0) begin
         $display("A bound property on the DUT was violated");
         fail_run("property violation");
      end
   end

   initial begin
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      seed      = 32'h59320487;
      clk       = 1'b0;
      arst_n    = 1'b0;
      host_req  = '0;
      log_ready = 1'b1;
      for (int i = 0; i < fpgarr_pkg::REG_COUNT; i++) begin
         ref_regs[i] = '0;
      end
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      test_name = "reset";
      check_value("log_valid", 0, log_valid);
      check_value("bvalid", 0, host_rsp.bvalid);
      check_value("rvalid", 0, host_rsp.rvalid);

      test_name = "directed";
      for (int i = 0; i < fpgarr_pkg::REG_COUNT; i++) begin
         write_reg(32'h4000_0000 + 4 * i, {8'hA5, 8'(i), 16'h5A3C}, 4'hF);
      end
      for (int i = 0; i < fpgarr_pkg::REG_COUNT; i++) begin
         read_reg(32'h4000_0000 + 4 * i);
      end

      test_name = "random";
      for (int i = 0; i < RANDOM_OPS; i++) begin
         addr = $random(seed);
         data = $random(seed);
         strb = $random(seed);
         if (($random(seed) & 1) != 0) begin
            write_reg(addr, data, strb);
         end else begin
            read_reg(addr);
         end
      end

      // Write and read in the same cycle give one bundle with all flags
      test_name = "concurrent";
      for (int i = 0; i < 4; i++) begin
         addr = $random(seed);
         data = $random(seed);
         fork
            write_reg(addr, data, 4'hF);
            read_reg(addr);
         join
      end

      test_name = "stall";
      stall_seen  = 1'b0;
      writes_done = 1'b0;
      log_ready <= 1'b0;
      fork
         begin
            repeat (STALL_WRITES) begin
               write_reg($random(seed), $random(seed), $random(seed));
            end
            writes_done = 1'b1;
         end
         begin
            // Gives up if every write went through without the host stalling
            do @(posedge clk);
            while (!(host_req.awvalid && !host_rsp.awready) && !writes_done);
            stall_seen = host_req.awvalid && !host_rsp.awready;
            repeat (5) @(posedge clk);
            log_ready <= 1'b1;
         end
      join
      check_value("host stalled", 1, stall_seen);

      test_name = "drain";
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      check_value("entries with all three flags", 1, triple_seen != 0);

      if (dut.props.fail_count == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("A bound property on the DUT was violated");
         fail_run("property violation");
      end
   end

endmodule
